/* alu.sv */
module alu (
  input  rv_pkg::alu_op_e op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD:  result = a + b;
      rv_pkg::ALU_SUB:  result = a - b;
      rv_pkg::ALU_SLL:  result = a << shamt;
      rv_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
      rv_pkg::ALU_SLTU: result = {31'b0, a < b};
      rv_pkg::ALU_XOR:  result = a ^ b;
      rv_pkg::ALU_SRL:  result = a >> shamt;
      rv_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> shamt);  // sign fill
      rv_pkg::ALU_OR:   result = a | b;
      rv_pkg::ALU_AND:  result = a & b;
      default:          result = '0;
    endcase
  end

endmodule

/* exec_core.sv */
module exec_core (
  input  logic                clock,
  input  logic                reset,
  input  logic                instr_valid,
  input  rv_pkg::word_t       instr,
  output logic                retire,
  output rv_pkg::retire_rec_t retire_rec,
  output rv_pkg::word_t       pc,
  output logic                trap
);

  rv_pkg::dec_t        dec;
  rv_pkg::word_t       src1;
  rv_pkg::word_t       src2;
  rv_pkg::word_t       alu_result;
  rv_pkg::word_t       mtvec;
  rv_pkg::word_t       mepc;
  rv_pkg::retire_rec_t rd_wr;
  rv_pkg::csr_wr_t     trap_wr1;
  rv_pkg::csr_wr_t     trap_wr2;

  instr_decoder u_instr_decoder (
    .instr (instr),
    .dec   (dec)
  );

  alu u_alu (
    .op     (dec.alu_op),
    .a      (src1),
    .b      (src2),
    .result (alu_result)
  );

  reg_csr_file u_reg_csr_file (
    .clock       (clock),
    .reset       (reset),
    .instr_valid (instr_valid),
    .dec         (dec),
    .alu_result  (alu_result),
    .trap_wr1    (trap_wr1),
    .trap_wr2    (trap_wr2),
    .src1        (src1),
    .src2        (src2),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .rd_wr       (rd_wr)
  );

  pc_trap_unit u_pc_trap_unit (
    .clock       (clock),
    .reset       (reset),
    .instr_valid (instr_valid),
    .dec         (dec),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .rd_wr       (rd_wr),
    .pc          (pc),
    .trap_wr1    (trap_wr1),
    .trap_wr2    (trap_wr2),
    .retire      (retire),
    .retire_rec  (retire_rec),
    .trap        (trap)
  );

endmodule

/* exec_core_golden.txt */
# name instr wr rd value trap next_pc, all numbers in hex
# names starting with b2b_ run with no idle cycle before them
csrr_mstatus     300022f3 1 5 00001800 0 80000004
addi_neg         ffb00093 1 1 fffffffb 0 80000008
addi_pos         00300113 1 2 00000003 0 8000000c
slt_neg          0020a1b3 1 3 00000001 0 80000010
sltu_neg         0020b233 1 4 00000000 0 80000014
sra_fill         4020d333 1 6 ffffffff 0 80000018
sub_rr           40110433 1 8 00000008 0 8000001c
lui_upper        123454b7 1 9 12345000 0 80000020
xori_imm         0ff4c513 1 a 123450ff 0 80000024
slli_imm         00411593 1 b 00000030 0 80000028
srai_imm         4010d613 1 c fffffffd 0 8000002c
write_x0         00710013 0 0 00000000 0 80000030
read_x0          000007b3 1 f 00000000 0 80000034
lui_mtvec        800010b7 1 1 80001000 0 80000038
csrrw_mtvec      305091f3 1 3 00000000 0 8000003c
read_mtvec       30502273 1 4 80001000 0 80000040
csrrs_set        300122f3 1 5 00001800 0 80000044
csrrc_clear      30013373 1 6 00001803 0 80000048
read_mstatus     300023f3 1 7 00001800 0 8000004c
write_mvendorid  f1109473 1 8 79737978 0 80000050
read_mvendorid   f1102473 1 8 79737978 0 80000054
read_unknown     7c0024f3 1 9 00000000 0 80000058
ecall            00000073 0 0 00000000 1 80001000
read_mepc        34102573 1 a 80000058 0 80001004
read_mcause      342025f3 1 b 0000000b 0 80001008
mret             30200073 0 0 00000000 0 80000058
illegal_opcode   ffffffff 0 0 00000000 1 80001000
mcause_illegal   34202673 1 c 00000002 0 80001004
add_x20          00210a33 0 0 00000000 1 80001000
b2b_addi_1       00100793 1 f 00000001 0 80001004
b2b_addi_2       00278793 1 f 00000003 0 80001008
b2b_add          00f78733 1 e 00000006 0 8000100c

/* instr_decoder.sv */
module instr_decoder (
  input  rv_pkg::word_t instr,
  output rv_pkg::dec_t  dec
);

  localparam logic [31:0] ECALL_WORD = 32'h0000_0073;
  localparam logic [31:0] MRET_WORD  = 32'h3020_0073;

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       illegal;
  logic       bad_idx;  // any used index >= 16
  rv_pkg::dec_t d;

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // alt selects sub / sra
  function automatic rv_pkg::alu_op_e op_from_f3(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  op = rv_pkg::ALU_SLL;
      3'b010:  op = rv_pkg::ALU_SLT;
      3'b011:  op = rv_pkg::ALU_SLTU;
      3'b100:  op = rv_pkg::ALU_XOR;
      3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  op = rv_pkg::ALU_OR;
      default: op = rv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    d          = '0;
    d.rd       = instr[10:7];
    d.rs1      = instr[18:15];
    d.rs2      = instr[23:20];
    d.imm      = {{20{instr[31]}}, instr[31:20]};  // i-type
    d.csr_addr = instr[31:20];
    d.alu_op   = rv_pkg::ALU_ADD;
    d.sys_op   = rv_pkg::SYS_NONE;
    illegal    = 1'b0;
    bad_idx    = 1'b0;

    case (instr[6:0])
      rv_pkg::OPC_OP: begin
        d.reg_we = 1'b1;
        d.alu_op = op_from_f3(funct3, funct7[5]);
        bad_idx  = instr[11] | instr[19] | instr[24];
        if (funct7 == 7'h20)
          illegal = !(funct3 == 3'b000 || funct3 == 3'b101);  // only sub, sra
        else if (funct7 != 7'h00)
          illegal = 1'b1;
      end
      rv_pkg::OPC_OP_IMM: begin
        d.reg_we = 1'b1;
        d.b_imm  = 1'b1;
        d.alu_op = op_from_f3(funct3, (funct3 == 3'b101) & funct7[5]);
        bad_idx  = instr[11] | instr[19];
        if (funct3 == 3'b001)
          illegal = (funct7 != 7'h00);
        else if (funct3 == 3'b101)
          illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
      end
      rv_pkg::OPC_LUI: begin
        d.reg_we = 1'b1;
        d.lui    = 1'b1;
        d.imm    = {instr[31:12], 12'b0};
        bad_idx  = instr[11];
      end
      rv_pkg::OPC_SYSTEM: begin
        case (funct3)
          3'b000: begin
            if (instr == ECALL_WORD)
              d.sys_op = rv_pkg::SYS_ECALL;
            else if (instr == MRET_WORD)
              d.sys_op = rv_pkg::SYS_MRET;
            else
              illegal = 1'b1;
          end
          3'b001, 3'b010, 3'b011: begin
            d.reg_we = 1'b1;
            bad_idx  = instr[11] | instr[19];
            if (funct3 == 3'b001)
              d.sys_op = rv_pkg::SYS_CSRRW;
            else if (funct3 == 3'b010)
              d.sys_op = rv_pkg::SYS_CSRRS;
            else
              d.sys_op = rv_pkg::SYS_CSRRC;
          end
          default: illegal = 1'b1;  // csr imm forms not supported
        endcase
      end
      default: illegal = 1'b1;
    endcase

    if (illegal || bad_idx) begin
      d.sys_op = rv_pkg::SYS_ILLEGAL;
      d.reg_we = 1'b0;
    end
  end

  assign dec = d;

  // every writing opcode must also reject rd >= 16
  always_comb begin
    if (dec.reg_we)
      assert (dec.sys_op != rv_pkg::SYS_ILLEGAL && !instr[11])
        else $error("register write enabled on an illegal decode or rd above x15");
  end

endmodule

/* pc_trap_unit.sv */
module pc_trap_unit (
  input  logic                clock,
  input  logic                reset,
  input  logic                instr_valid,
  input  rv_pkg::dec_t        dec,
  input  rv_pkg::word_t       mtvec,
  input  rv_pkg::word_t       mepc,
  input  rv_pkg::retire_rec_t rd_wr,
  output rv_pkg::word_t       pc,
  output rv_pkg::csr_wr_t     trap_wr1,
  output rv_pkg::csr_wr_t     trap_wr2,
  output logic                retire,
  output rv_pkg::retire_rec_t retire_rec,
  output logic                trap
);

  logic              take_trap;
  rv_pkg::redirect_t redir;
  rv_pkg::word_t     next_pc;

  assign take_trap = (dec.sys_op == rv_pkg::SYS_ECALL) || (dec.sys_op == rv_pkg::SYS_ILLEGAL);

  assign trap_wr1.en   = instr_valid && take_trap;
  assign trap_wr1.addr = rv_pkg::CSR_MEPC;
  assign trap_wr1.data = pc;  // pc of the trapping instruction

  assign trap_wr2.en   = instr_valid && take_trap;
  assign trap_wr2.addr = rv_pkg::CSR_MCAUSE;
  assign trap_wr2.data = (dec.sys_op == rv_pkg::SYS_ECALL) ? rv_pkg::CAUSE_ECALL_M
                                                           : rv_pkg::CAUSE_ILLEGAL;

  assign redir.en = take_trap || (dec.sys_op == rv_pkg::SYS_MRET);
  assign redir.pc = take_trap ? mtvec : mepc;

  assign next_pc = redir.en ? redir.pc : pc + 32'd4;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc         <= rv_pkg::RESET_PC;
      retire     <= 1'b0;
      retire_rec <= '0;
      trap       <= 1'b0;
    end else begin
      retire <= instr_valid;  // one-cycle pulse
      trap   <= instr_valid && take_trap;
      if (instr_valid) begin
        pc         <= next_pc;
        retire_rec <= rd_wr;
      end
    end
  end

  // a trap comes from the register file with no write
  a_retire_after_valid: assert property (@(posedge clock) disable iff (reset)
    (retire || trap) |-> $past(instr_valid) && !(trap && retire_rec.wr))
    else $error("retire or trap without a preceding instruction, or a trap writes rd");

endmodule

/* reg_csr_file.sv */
module reg_csr_file (
  input  logic                clock,
  input  logic                reset,
  input  logic                instr_valid,
  input  rv_pkg::dec_t        dec,
  input  rv_pkg::word_t       alu_result,
  input  rv_pkg::csr_wr_t     trap_wr1,
  input  rv_pkg::csr_wr_t     trap_wr2,
  output rv_pkg::word_t       src1,
  output rv_pkg::word_t       src2,
  output rv_pkg::word_t       mtvec,
  output rv_pkg::word_t       mepc,
  output rv_pkg::retire_rec_t rd_wr
);

  rv_pkg::word_t   regs [rv_pkg::NUM_REGS];
  rv_pkg::word_t   mstatus;
  rv_pkg::word_t   mcause;
  rv_pkg::word_t   csr_src;
  rv_pkg::csr_wr_t csr_op_wr;  // csr instruction write
  rv_pkg::csr_wr_t csr_port [2];
  logic            csr_op;

  assign src1 = regs[dec.rs1];
  assign src2 = dec.b_imm ? dec.imm : regs[dec.rs2];  // operand b

  always_comb begin
    case (dec.csr_addr)
      rv_pkg::CSR_MSTATUS:   csr_src = mstatus;
      rv_pkg::CSR_MTVEC:     csr_src = mtvec;
      rv_pkg::CSR_MEPC:      csr_src = mepc;
      rv_pkg::CSR_MCAUSE:    csr_src = mcause;
      rv_pkg::CSR_MVENDORID: csr_src = rv_pkg::MVENDORID_VAL;
      rv_pkg::CSR_MARCHID:   csr_src = rv_pkg::MARCHID_VAL;
      default:               csr_src = '0;
    endcase
  end

  assign csr_op = (dec.sys_op == rv_pkg::SYS_CSRRW) || (dec.sys_op == rv_pkg::SYS_CSRRS) ||
                  (dec.sys_op == rv_pkg::SYS_CSRRC);

  always_comb begin
    csr_op_wr.addr = dec.csr_addr;
    case (dec.sys_op)
      rv_pkg::SYS_CSRRW: begin
        csr_op_wr.en   = 1'b1;
        csr_op_wr.data = src1;
      end
      rv_pkg::SYS_CSRRS: begin
        csr_op_wr.en   = (dec.rs1 != '0);  // csrr must not write
        csr_op_wr.data = csr_src | src1;
      end
      rv_pkg::SYS_CSRRC: begin
        csr_op_wr.en   = (dec.rs1 != '0);
        csr_op_wr.data = csr_src & ~src1;
      end
      default: begin
        csr_op_wr.en   = 1'b0;
        csr_op_wr.data = src1;
      end
    endcase
  end

  // port 1 shared by trap mepc and csr instruction
  assign csr_port[0] = trap_wr1.en ? trap_wr1 : csr_op_wr;
  assign csr_port[1] = trap_wr2;

  assign rd_wr.wr    = instr_valid && dec.reg_we && (dec.rd != '0);
  assign rd_wr.rd    = dec.rd;
  assign rd_wr.value = csr_op ? csr_src : (dec.lui ? dec.imm : alu_result);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rv_pkg::NUM_REGS; i++)
        regs[i] <= '0;
      mstatus <= rv_pkg::MSTATUS_RESET;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (instr_valid) begin
      if (rd_wr.wr)
        regs[rd_wr.rd] <= rd_wr.value;
      for (int p = 0; p < 2; p++) begin  // port 2 applied last
        if (csr_port[p].en) begin
          case (csr_port[p].addr)
            rv_pkg::CSR_MSTATUS: mstatus <= csr_port[p].data;
            rv_pkg::CSR_MTVEC:   mtvec   <= csr_port[p].data;
            rv_pkg::CSR_MEPC:    mepc    <= csr_port[p].data;
            rv_pkg::CSR_MCAUSE:  mcause  <= csr_port[p].data;
            default: ;  // read-only or unknown
          endcase
        end
      end
    end
  end

  a_port1_single_src: assert property (@(posedge clock) disable iff (reset)
    !(trap_wr1.en && csr_op_wr.en))
    else $error("trap and csr instruction collide on port 1");

  a_x0_zero: assert property (@(posedge clock) disable iff (reset) regs[0] == '0)
    else $error("x0 changed");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the exec_core testbench with verilator and run it
cd "$(dirname "$0")" &&
  verilator --binary --assert -f sources.f --top-module tb_exec_core -o sim_exec_core &&
  ./obj_dir/sim_exec_core || exit 1

/* rv_pkg.sv */
package rv_pkg;

  localparam int XLEN       = 32;
  localparam int NUM_REGS   = 16;
  localparam int CSR_ADDR_W = 12;

  typedef logic [XLEN-1:0]             word_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

  localparam word_t RESET_PC      = 32'h8000_0000;
  localparam word_t MSTATUS_RESET = 32'h0000_1800;  // mpp = machine
  localparam word_t MVENDORID_VAL = 32'h7973_7978;
  localparam word_t MARCHID_VAL   = 32'h017d_9f58;
  localparam word_t CAUSE_ECALL_M = 32'd11;
  localparam word_t CAUSE_ILLEGAL = 32'd2;

  typedef enum logic [CSR_ADDR_W-1:0] {
    CSR_MSTATUS   = 12'h300,
    CSR_MTVEC     = 12'h305,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MVENDORID = 12'hf11,
    CSR_MARCHID   = 12'hf12
  } csr_addr_e;

  // major opcodes we decode, everything else is illegal
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  typedef enum logic [2:0] {
    SYS_NONE,
    SYS_CSRRW,
    SYS_CSRRS,
    SYS_CSRRC,
    SYS_ECALL,
    SYS_MRET,
    SYS_ILLEGAL
  } sys_op_e;

  typedef struct packed {
    reg_idx_t              rs1;
    reg_idx_t              rs2;
    reg_idx_t              rd;
    logic                  reg_we;
    logic                  b_imm;     // operand b from imm
    word_t                 imm;
    alu_op_e               alu_op;
    sys_op_e               sys_op;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic                  lui;       // result is imm alone
  } dec_t;

  typedef struct packed {
    logic                  en;
    logic [CSR_ADDR_W-1:0] addr;
    word_t                 data;
  } csr_wr_t;

  typedef struct packed {
    logic  en;
    word_t pc;
  } redirect_t;

  typedef struct packed {
    logic     wr;
    reg_idx_t rd;
    word_t    value;
  } retire_rec_t;

endpackage

/* sources.f */
rv_pkg.sv
instr_decoder.sv
alu.sv
reg_csr_file.sv
pc_trap_unit.sv
exec_core.sv
tb_exec_core.sv

/* tb_exec_core.sv */
module tb_exec_core;

  logic                clock;
  logic                reset;
  logic                instr_valid;
  rv_pkg::word_t       instr;
  logic                retire;
  rv_pkg::retire_rec_t retire_rec;
  rv_pkg::word_t       pc;
  logic                trap;

  string               names [$];
  rv_pkg::word_t       instrs [$];
  rv_pkg::retire_rec_t exp_recs [$];
  logic                exp_traps [$];
  rv_pkg::word_t       exp_pcs [$];
  int                  cycles = 0;
  int                  cycle_limit;

  exec_core u_exec_core (
    .clock       (clock),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .retire      (retire),
    .retire_rec  (retire_rec),
    .pc          (pc),
    .trap        (trap)
  );

  initial clock = 1'b0;
  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout reached after %0d cycles", cycles);
      $display("TEST FAILED");
      $fatal(1, "run did not finish within the cycle limit");
    end
  end

  task automatic check_retire(input string name, input rv_pkg::retire_rec_t exp_rec,
                              input logic exp_trap, input rv_pkg::retire_rec_t act_rec,
                              input logic act_trap);
    logic  ok;
    string exp_s;
    string act_s;
    ok = (exp_rec.wr === act_rec.wr) && (exp_trap === act_trap);
    if (exp_rec.wr)  // rd and value only count on a write
      ok = ok && (exp_rec.rd === act_rec.rd) && (exp_rec.value === act_rec.value);
    if (!ok) begin
      exp_s = $sformatf("wr=%0b rd=%0d value=%h trap=%0b", exp_rec.wr, exp_rec.rd,
                        exp_rec.value, exp_trap);
      act_s = $sformatf("wr=%0b rd=%0d value=%h trap=%0b", act_rec.wr, act_rec.rd,
                        act_rec.value, act_trap);
      $display("mismatch in %s: expected %s actual %s", name, exp_s, act_s);
      $display("TEST FAILED");
      $fatal(1, "retire record check failed");
    end
  endtask

  task automatic check_pc(input string name, input rv_pkg::word_t exp_pc,
                          input rv_pkg::word_t act_pc);
    if (exp_pc !== act_pc) begin
      $display("mismatch in %s: expected pc=%h actual pc=%h", name, exp_pc, act_pc);
      $display("TEST FAILED");
      $fatal(1, "pc check failed");
    end
  endtask

  task automatic load_golden();
    int                  fd;
    int                  n;
    string               line;
    string               name;
    logic [31:0]         word;
    logic [31:0]         wr;
    logic [31:0]         rd;
    logic [31:0]         value;
    logic [31:0]         trp;
    logic [31:0]         next_pc;
    rv_pkg::retire_rec_t rec;
    fd = $fopen("exec_core_golden.txt", "r");
    if (fd == 0) begin
      $display("golden file exec_core_golden.txt could not be opened");
      $display("TEST FAILED");
      $fatal(1, "missing golden file");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == 8'h23)
        continue;  // blank or comment
      n = $sscanf(line, "%s %h %h %h %h %h %h", name, word, wr, rd, value, trp, next_pc);
      if (n != 7) begin
        $display("golden line could not be parsed: %s", line);
        $display("TEST FAILED");
        $fatal(1, "bad golden file");
      end
      rec.wr    = wr[0];
      rec.rd    = rd[3:0];
      rec.value = value;
      names.push_back(name);
      instrs.push_back(word);
      exp_recs.push_back(rec);
      exp_traps.push_back(trp[0]);
      exp_pcs.push_back(next_pc);
    end
    $fclose(fd);
  endtask

  initial begin
    int unsigned gap;
    instr_valid = 1'b0;
    instr       = '0;
    reset       = 1'b1;
    void'($urandom(32'hc3d89a57));
    load_golden();
    if (instrs.size() == 0) begin
      $display("golden file holds no instructions");
      $display("TEST FAILED");
      $fatal(1, "empty golden file");
    end
    cycle_limit = instrs.size() * 4 + 20;
    repeat (4) @(negedge clock);
    reset = 1'b0;

    if (retire !== 1'b0) begin
      $display("retire is not low right after reset");
      $display("TEST FAILED");
      $fatal(1, "bad reset state");
    end
    check_pc("reset_pc", rv_pkg::RESET_PC, pc);
    check_retire("reset_state", '0, 1'b0, retire_rec, trap);

    foreach (instrs[i]) begin
      if (names[i].substr(0, 3) != "b2b_") begin
        gap = $urandom % 3;
        repeat (gap) begin  // idle gap, pulses must be gone
          @(negedge clock);
          if (retire !== 1'b0 || trap !== 1'b0) begin
            $display("retire or trap still high in an idle cycle before %s", names[i]);
            $display("TEST FAILED");
            $fatal(1, "retire or trap longer than one cycle");
          end
        end
      end
      instr_valid = 1'b1;
      instr       = instrs[i];
      @(negedge clock);
      instr_valid = 1'b0;
      while (!retire)
        @(negedge clock);
      check_retire(names[i], exp_recs[i], exp_traps[i], retire_rec, trap);
      check_pc(names[i], exp_pcs[i], pc);
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule
